/* logic/axi_rd_pkg.sv */
// AXI4 read-bus field types
// Fixed AR attribute values driven by the read master
`default_nettype none

package axi_rd_pkg;

   // One R-channel word, also one stream word
   typedef logic [31:0] data_t;

   // AR attribute fields
   typedef logic [2:0] size_t;
   typedef logic [1:0] burst_type_t;
   typedef logic [3:0] cache_t;
   typedef logic [3:0] qos_t;
   typedef logic [1:0] lock_t;

   // Beats are always 4 bytes wide
   localparam size_t AR_SIZE_WORD = 3'd2;

   // Incrementing bursts only
   localparam burst_type_t AR_BURST_INCR = 2'd1;

   // Normal non-cacheable, modifiable
   localparam cache_t AR_CACHE_DEFAULT = 4'd2;

   // No QoS and no exclusive access
   localparam qos_t AR_QOS_NONE = 4'd0;
   localparam lock_t AR_LOCK_NORMAL = 2'd0;

endpackage

`default_nettype wire

/* logic/xfer_pkg.sv */
// Transfer-engine constants for the burst planner
// Planner FSM state encoding
`default_nettype none

package xfer_pkg;

   // Bytes moved per beat
   localparam int unsigned BEAT_BYTES = 4;

   // AXI bursts must not cross this boundary
   localparam int unsigned BOUNDARY_BYTES = 4096;

   // Address bit that toggles when a 4 KiB page is crossed
   localparam int unsigned BOUNDARY_BIT = 12;

   // Planner states
   typedef enum logic [1:0] {
      WAIT_START  = 2'd0,
      START_BURST = 2'd1,
      TRANSF_DATA = 2'd2
   } plan_state_t;

endpackage

`default_nettype wire

/* logic/axi_r_if.sv */
// AXI4 read-data channel bundle
// Modports for the skid buffer and the burst planner
`timescale 1ns/10ps
`default_nettype none

interface axi_r_if;

   axi_rd_pkg::data_t rdata;
   logic              rvalid;
   logic              rlast;
   logic              rready;

   // Data path side, owns rready
   modport skid (
      input  rdata,
      input  rvalid,
      output rready
   );

   // Planner only observes beat acceptance
   modport watch (
      input rvalid,
      input rlast,
      input rready
   );

endinterface

`default_nettype wire

/* logic/ar_burst_planner.sv */
// AXI4 read-address planner
// Splits a request at a 4 KiB boundary and drives the AR channel
`timescale 1ns/10ps
`default_nettype none

module ar_burst_planner #(
   parameter int AXI_ADDR_W = 32,
   parameter int AXI_LEN_W  = 8,
   parameter int AXI_ID_W   = 1
) (
   input  wire                      clk_i,
   input  wire                      reset_i,

   // Request side
   input  wire                      start_i,
   input  wire [AXI_ADDR_W-1:0]     addr_i,
   input  wire [AXI_LEN_W:0]        length_i,
   output logic                     busy_o,

   // AR channel
   output logic [AXI_ADDR_W-1:0]    araddr_o,
   output logic [AXI_LEN_W-1:0]     arlen_o,
   output logic                     arvalid_o,
   input  wire                      arready_i,
   output logic [AXI_ID_W-1:0]      arid_o,
   output axi_rd_pkg::size_t        arsize_o,
   output axi_rd_pkg::burst_type_t  arburst_o,
   output axi_rd_pkg::lock_t        arlock_o,
   output axi_rd_pkg::cache_t       arcache_o,
   output axi_rd_pkg::qos_t         arqos_o,

   // R channel, observed only
   axi_r_if.watch                   r
);

   // FSM state
   xfer_pkg::plan_state_t state;
   xfer_pkg::plan_state_t state_nxt;

   // Current burst and the beats still owed after it
   logic [AXI_ADDR_W-1:0] araddr;
   logic [AXI_ADDR_W-1:0] araddr_nxt;
   logic [AXI_LEN_W-1:0]  arlen;
   logic [AXI_LEN_W-1:0]  arlen_nxt;
   logic [AXI_LEN_W:0]    remaining;
   logic [AXI_LEN_W:0]    remaining_nxt;

   // Request geometry
   logic [AXI_ADDR_W:0]                   last_addr;
   logic [xfer_pkg::BOUNDARY_BIT-1:0]     page_offset;
   logic [AXI_LEN_W:0]                    page_words;
   logic [AXI_LEN_W:0]                    first_len;
   logic                                  crosses_page;
   logic [AXI_ADDR_W-1:0]                 next_page;
   logic                                  last_beat;

   // Byte address of the last word of the whole request
   always_comb begin
      last_addr = {1'b0, addr_i}
                + (AXI_ADDR_W+1)'(length_i) * (AXI_ADDR_W+1)'(xfer_pkg::BEAT_BYTES)
                - 1'b1;
      page_offset  = addr_i[xfer_pkg::BOUNDARY_BIT-1:0];
      crosses_page = addr_i[xfer_pkg::BOUNDARY_BIT] != last_addr[xfer_pkg::BOUNDARY_BIT];
      // Words left up to the end of the start page
      page_words = (AXI_LEN_W+1)'((xfer_pkg::BOUNDARY_BYTES - page_offset)
                                  / xfer_pkg::BEAT_BYTES);
      first_len  = crosses_page ? page_words : length_i;
   end

   // Base of the page after the current burst
   assign next_page = {araddr[AXI_ADDR_W-1:xfer_pkg::BOUNDARY_BIT] + 1'b1,
                       {xfer_pkg::BOUNDARY_BIT{1'b0}}};

   // Final beat of the running burst taken by the skid buffer
   assign last_beat = r.rvalid && r.rready && r.rlast;

   always_comb begin
      state_nxt     = state;
      araddr_nxt    = araddr;
      arlen_nxt     = arlen;
      remaining_nxt = remaining;

      case (state)
         xfer_pkg::WAIT_START: begin
            if (start_i) begin
               araddr_nxt    = addr_i;
               arlen_nxt     = AXI_LEN_W'(first_len - 1'b1);
               remaining_nxt = length_i - first_len;
               state_nxt     = xfer_pkg::START_BURST;
            end
         end

         // Hold the address until the slave takes it
         xfer_pkg::START_BURST: begin
            if (arready_i) begin
               state_nxt = xfer_pkg::TRANSF_DATA;
            end
         end

         xfer_pkg::TRANSF_DATA: begin
            if (last_beat) begin
               if (remaining == '0) begin
                  state_nxt = xfer_pkg::WAIT_START;
               end else begin
                  // Second half of a split request
                  araddr_nxt    = next_page;
                  arlen_nxt     = AXI_LEN_W'(remaining - 1'b1);
                  remaining_nxt = '0;
                  state_nxt     = xfer_pkg::START_BURST;
               end
            end
         end

         default: begin
            state_nxt = xfer_pkg::WAIT_START;
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state     <= xfer_pkg::WAIT_START;
         remaining <= '0;
      end else begin
         state     <= state_nxt;
         remaining <= remaining_nxt;
      end
   end

   // Burst payload, only meaningful while arvalid or a burst runs
   always_ff @(posedge clk_i) begin
      araddr <= araddr_nxt;
      arlen  <= arlen_nxt;
   end

   assign busy_o    = state != xfer_pkg::WAIT_START;
   assign arvalid_o = state == xfer_pkg::START_BURST;
   assign araddr_o  = araddr;
   assign arlen_o   = arlen;

   // Fixed bus attributes
   assign arid_o    = '0;
   assign arsize_o  = axi_rd_pkg::AR_SIZE_WORD;
   assign arburst_o = axi_rd_pkg::AR_BURST_INCR;
   assign arlock_o  = axi_rd_pkg::AR_LOCK_NORMAL;
   assign arcache_o = axi_rd_pkg::AR_CACHE_DEFAULT;
   assign arqos_o   = axi_rd_pkg::AR_QOS_NONE;

endmodule

`default_nettype wire

/* logic/r_skid_buffer.sv */
// R channel to stream adapter
// Registered RREADY with a one-beat holding register
`timescale 1ns/10ps
`default_nettype none

module r_skid_buffer (
   input  wire                clk_i,
   input  wire                reset_i,

   // AXI read data
   axi_r_if.skid              r,

   // Stream output
   output axi_rd_pkg::data_t  axis_data_o,
   output logic               axis_valid_o,
   input  wire                axis_ready_i
);

   logic              rready;
   axi_rd_pkg::data_t held_data;
   logic              held_valid;

   // Slave sees the consumer's ready one cycle late
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         rready <= 1'b0;
      end else begin
         rready <= axis_ready_i;
      end
   end

   assign r.rready = rready;

   // Track the live channel while accepting, freeze on stall
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         held_valid <= 1'b0;
      end else if (rready) begin
         held_valid <= r.rvalid;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rready) begin
         held_data <= r.rdata;
      end
   end

   // Live beat while accepting, otherwise the beat caught last cycle
   assign axis_data_o  = rready ? r.rdata : held_data;
   assign axis_valid_o = rready ? r.rvalid : held_valid;

endmodule

`default_nettype wire

/* logic/axis_read_dma.sv */
// AXI4 read master with stream output
// Top level joining the burst planner and the R-channel skid buffer
`timescale 1ns/10ps
`default_nettype none

module axis_read_dma #(
   parameter int AXI_ADDR_W = 32,
   parameter int AXI_LEN_W  = 8,
   parameter int AXI_ID_W   = 1
) (
   input  wire                      clk_i,
   input  wire                      reset_i,

   // Request
   input  wire                      start_i,
   input  wire [AXI_ADDR_W-1:0]     addr_i,
   input  wire [AXI_LEN_W:0]        length_i,
   output logic                     busy_o,

   // AR channel
   output logic [AXI_ADDR_W-1:0]    araddr_o,
   output logic [AXI_LEN_W-1:0]     arlen_o,
   output logic                     arvalid_o,
   input  wire                      arready_i,
   output logic [AXI_ID_W-1:0]      arid_o,
   output axi_rd_pkg::size_t        arsize_o,
   output axi_rd_pkg::burst_type_t  arburst_o,
   output axi_rd_pkg::lock_t        arlock_o,
   output axi_rd_pkg::cache_t       arcache_o,
   output axi_rd_pkg::qos_t         arqos_o,

   // R channel
   input  wire axi_rd_pkg::data_t   rdata_i,
   input  wire                      rvalid_i,
   input  wire                      rlast_i,
   output logic                     rready_o,

   // Stream output
   output axi_rd_pkg::data_t        axis_data_o,
   output logic                     axis_valid_o,
   input  wire                      axis_ready_i
);

   axi_r_if r_if ();

   assign r_if.rdata  = rdata_i;
   assign r_if.rvalid = rvalid_i;
   assign r_if.rlast  = rlast_i;
   assign rready_o    = r_if.rready;

   ar_burst_planner #(
      .AXI_ADDR_W (AXI_ADDR_W),
      .AXI_LEN_W  (AXI_LEN_W),
      .AXI_ID_W   (AXI_ID_W)
   ) i_ar_burst_planner (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .start_i    (start_i),
      .addr_i     (addr_i),
      .length_i   (length_i),
      .busy_o     (busy_o),
      .araddr_o   (araddr_o),
      .arlen_o    (arlen_o),
      .arvalid_o  (arvalid_o),
      .arready_i  (arready_i),
      .arid_o     (arid_o),
      .arsize_o   (arsize_o),
      .arburst_o  (arburst_o),
      .arlock_o   (arlock_o),
      .arcache_o  (arcache_o),
      .arqos_o    (arqos_o),
      .r          (r_if.watch)
   );

   r_skid_buffer i_r_skid_buffer (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .r            (r_if.skid),
      .axis_data_o  (axis_data_o),
      .axis_valid_o (axis_valid_o),
      .axis_ready_i (axis_ready_i)
   );

endmodule

`default_nettype wire

/* verif/axi_mem_model.sv */
// AXI4 read slave model for the read master testbench
// Address-derived read data, random AR stalls and rvalid gaps
`timescale 1ns/10ps
`default_nettype none

module axi_mem_model #(
   parameter int AXI_ADDR_W = 32,
   parameter int AXI_LEN_W  = 8
) (
   input  wire                   clk_i,
   input  wire                   reset_i,
   input  wire [AXI_ADDR_W-1:0]  araddr_i,
   input  wire [AXI_LEN_W-1:0]   arlen_i,
   input  wire                   arvalid_i,
   output logic                  arready_o,
   output logic [31:0]           rdata_o,
   output logic                  rvalid_o,
   output logic                  rlast_o,
   input  wire                   rready_i
);

   localparam logic [31:0] DATA_PATTERN = 32'hA5A5_0000;

   initial begin
      logic                  rst;
      logic                  ar_hs;
      logic                  r_hs;
      logic [AXI_ADDR_W-1:0] ar_addr;
      logic [AXI_LEN_W-1:0]  ar_len;
      logic                  active;
      logic [AXI_ADDR_W-1:0] base;
      logic [AXI_LEN_W-1:0]  len;
      logic [AXI_LEN_W:0]    sent;

      arready_o = 1'b0;
      rvalid_o  = 1'b0;
      rlast_o   = 1'b0;
      rdata_o   = '0;
      active    = 1'b0;
      base      = '0;
      len       = '0;
      sent      = '0;
      forever begin
         // Handshakes complete on the edge itself
         @(posedge clk_i);
         rst     = reset_i;
         ar_hs   = arvalid_i && arready_o;
         r_hs    = rvalid_o && rready_i;
         ar_addr = araddr_i;
         ar_len  = arlen_i;
         #1;
         if (rst) begin
            arready_o = 1'b0;
            rvalid_o  = 1'b0;
            rlast_o   = 1'b0;
            active    = 1'b0;
         end else begin
            arready_o = 1'b0;
            if (ar_hs) begin
               active = 1'b1;
               base   = ar_addr;
               len    = ar_len;
               sent   = '0;
            end
            if (r_hs) begin
               sent     = sent + 1'b1;
               rvalid_o = 1'b0;
               if (rlast_o) begin
                  active = 1'b0;
               end
               rlast_o = 1'b0;
            end
            // Random stall before the address is taken
            if (!active && arvalid_i && ($urandom % 3) == 0) begin
               arready_o = 1'b1;
            end
            // Gaps between beats
            if (active && !rvalid_o && ($urandom % 4) != 0) begin
               rvalid_o = 1'b1;
               rdata_o  = (base + AXI_ADDR_W'(sent) * 4) ^ DATA_PATTERN;
               rlast_o  = sent == {1'b0, len};
            end
         end
      end
   end

endmodule

`default_nettype wire

/* verif/axis_read_dma_assert.sv */
// Concurrent checks on the read master top level
// AR legality, stream data order and word count per request
`timescale 1ns/10ps
`default_nettype none

module axis_read_dma_assert #(
   parameter int AXI_ADDR_W = 32,
   parameter int AXI_LEN_W  = 8,
   parameter int AXI_ID_W   = 1
) (
   input wire                   clk_i,
   input wire                   reset_i,
   input wire                   start_i,
   input wire [AXI_ADDR_W-1:0]  addr_i,
   input wire [AXI_LEN_W:0]     length_i,
   input wire                   busy_o,
   input wire [AXI_ADDR_W-1:0]  araddr_o,
   input wire [AXI_LEN_W-1:0]   arlen_o,
   input wire                   arvalid_o,
   input wire                   arready_i,
   input wire [AXI_ID_W-1:0]    arid_o,
   input wire [2:0]             arsize_o,
   input wire [1:0]             arburst_o,
   input wire [1:0]             arlock_o,
   input wire [3:0]             arcache_o,
   input wire [3:0]             arqos_o,
   input wire                   rready_o,
   input wire [31:0]            axis_data_o,
   input wire                   axis_valid_o,
   input wire                   axis_ready_i
);

   int unsigned fail_count = 0;

   logic [AXI_ADDR_W-1:0] exp_addr;
   logic [AXI_LEN_W:0]    req_len;
   logic [AXI_LEN_W:0]    word_count;
   logic [AXI_ADDR_W:0]   burst_end;

   // Last byte of the burst on the AR channel
   assign burst_end = {1'b0, araddr_o} + ((AXI_ADDR_W+1)'(arlen_o) + 1) * 4 - 1;

   // Expected stream address and words seen for the running request
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         exp_addr   <= '0;
         req_len    <= '0;
         word_count <= '0;
      end else if (start_i && !busy_o) begin
         exp_addr   <= addr_i;
         req_len    <= length_i;
         word_count <= '0;
      end else if (axis_valid_o && axis_ready_i) begin
         exp_addr   <= exp_addr + 4;
         word_count <= word_count + 1'b1;
      end
   end

   reset_idle: assert property (@(posedge clk_i)
      reset_i |=> !arvalid_o && !rready_o && !busy_o && !axis_valid_o)
      else begin
         fail_count++;
         $error("Outputs not idle after reset");
      end

   ar_in_page: assert property (@(posedge clk_i) disable iff (reset_i)
      arvalid_o && arready_i |->
         burst_end[12] == araddr_o[12] && arsize_o == 3'd2 && arburst_o == 2'd1)
      else begin
         fail_count++;
         $error("AR burst at %h len %0d crosses a page or has bad attributes",
                $sampled(araddr_o), $sampled(arlen_o));
      end

   // Single ID, normal access, modifiable non-cacheable, no QoS
   ar_fixed_attrs: assert property (@(posedge clk_i) disable iff (reset_i)
      arvalid_o |->
         arid_o == '0 && arlock_o == 2'd0 && arcache_o == 4'd2 && arqos_o == 4'd0)
      else begin
         fail_count++;
         $error("AR id, lock, cache or qos differ from the fixed values");
      end

   ar_stable: assert property (@(posedge clk_i) disable iff (reset_i)
      arvalid_o && !arready_i |=> arvalid_o && $stable(araddr_o) && $stable(arlen_o))
      else begin
         fail_count++;
         $error("AR request dropped or changed before arready");
      end

   rready_delay: assert property (@(posedge clk_i) disable iff (reset_i)
      rready_o == $past(axis_ready_i))
      else begin
         fail_count++;
         $error("rready does not follow the stream ready one cycle late");
      end

   stream_data: assert property (@(posedge clk_i) disable iff (reset_i)
      axis_valid_o && axis_ready_i |-> axis_data_o == (exp_addr ^ 32'hA5A5_0000))
      else begin
         fail_count++;
         $error("error stream_data expected %h actual %h",
                $sampled(exp_addr) ^ 32'hA5A5_0000, $sampled(axis_data_o));
      end

   // At most the held beat may still be pending when busy drops
   word_total: assert property (@(posedge clk_i) disable iff (reset_i)
      $fell(busy_o) |-> word_count + axis_valid_o == req_len)
      else begin
         fail_count++;
         $error("error word_total expected %0d actual %0d",
                $sampled(req_len), $sampled(word_count) + $sampled(axis_valid_o));
      end

   start_to_ar: assert property (@(posedge clk_i) disable iff (reset_i)
      start_i && !busy_o |=> arvalid_o)
      else begin
         fail_count++;
         $error("No AR request in the cycle after an accepted start");
      end

endmodule

`default_nettype wire

/* verif/tb_axis_read_dma.sv */
// Testbench for the AXI4 read master with stream output
// Clock, reset, request sequence and random stream back-pressure
`timescale 1ns/10ps
`default_nettype none

module tb_axis_read_dma;

   localparam int AXI_ADDR_W = 32;
   localparam int AXI_LEN_W  = 8;
   localparam int AXI_ID_W   = 1;
   // Cycles allowed for one request to drain
   localparam int TIMEOUT_CYCLES = 5000;

   logic                     clk_i = 1'b0;
   logic                     reset_i;
   logic                     start_i;
   logic [AXI_ADDR_W-1:0]    addr_i;
   logic [AXI_LEN_W:0]       length_i;
   logic                     busy_o;
   logic [AXI_ADDR_W-1:0]    araddr_o;
   logic [AXI_LEN_W-1:0]     arlen_o;
   logic                     arvalid_o;
   logic                     arready_i;
   logic [AXI_ID_W-1:0]      arid_o;
   axi_rd_pkg::size_t        arsize_o;
   axi_rd_pkg::burst_type_t  arburst_o;
   axi_rd_pkg::lock_t        arlock_o;
   axi_rd_pkg::cache_t       arcache_o;
   axi_rd_pkg::qos_t         arqos_o;
   axi_rd_pkg::data_t        rdata_i;
   logic                     rvalid_i;
   logic                     rlast_i;
   logic                     rready_o;
   axi_rd_pkg::data_t        axis_data_o;
   logic                     axis_valid_o;
   logic                     axis_ready_i;
   int unsigned              assert_failures;

   always #10 clk_i = ~clk_i;

   axis_read_dma #(
      .AXI_ADDR_W (AXI_ADDR_W),
      .AXI_LEN_W  (AXI_LEN_W),
      .AXI_ID_W   (AXI_ID_W)
   ) i_axis_read_dma (.*);

   axi_mem_model #(
      .AXI_ADDR_W (AXI_ADDR_W),
      .AXI_LEN_W  (AXI_LEN_W)
   ) i_axi_mem_model (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .araddr_i   (araddr_o),
      .arlen_i    (arlen_o),
      .arvalid_i  (arvalid_o),
      .arready_o  (arready_i),
      .rdata_o    (rdata_i),
      .rvalid_o   (rvalid_i),
      .rlast_o    (rlast_i),
      .rready_i   (rready_o)
   );

   bind axis_read_dma axis_read_dma_assert #(
      .AXI_ADDR_W (AXI_ADDR_W),
      .AXI_LEN_W  (AXI_LEN_W),
      .AXI_ID_W   (AXI_ID_W)
   ) i_axis_read_dma_assert (.*);

   assign assert_failures = i_axis_read_dma.i_axis_read_dma_assert.fail_count;

   // Stop at the first failed check
   always @(negedge clk_i) begin
      if (assert_failures != 0) begin
         $display("TESTS FAILED");
         $fatal(1, "Assertion failure in the DUT checker");
      end
   end

   // One cycle on, new random stream ready
   task automatic next_cycle();
      @(posedge clk_i);
      #1;
      axis_ready_i = ($urandom % 4) != 0;
   endtask

   task automatic wait_for_drain(input string name);
      int cycles;
      cycles = 0;
      @(negedge clk_i);
      while (busy_o || axis_valid_o) begin
         if (cycles == TIMEOUT_CYCLES) begin
            $display("Timeout: request %s did not complete", name);
            $display("TESTS FAILED");
            $fatal(1, "Request did not complete in time");
         end
         cycles++;
         next_cycle();
         @(negedge clk_i);
      end
   endtask

   task automatic run_request(input string name, input logic [AXI_ADDR_W-1:0] addr,
                              input logic [AXI_LEN_W:0] len);
      next_cycle();
      start_i  = 1'b1;
      addr_i   = addr;
      length_i = len;
      next_cycle();
      start_i  = 1'b0;
      wait_for_drain(name);
   endtask

   initial begin
      void'($urandom(83));
      reset_i      = 1'b1;
      start_i      = 1'b0;
      addr_i       = '0;
      length_i     = '0;
      axis_ready_i = 1'b0;
      repeat (3) @(posedge clk_i);
      #1;
      reset_i = 1'b0;

      run_request("short_in_page", 32'h0000_1010, 9'd5);
      run_request("page_end", 32'h0000_2F00, 9'd64);
      run_request("odd_page_cross", 32'h0000_5FF8, 9'd3);
      // Crossing request followed directly by the longest one
      run_request("page_cross", 32'h0000_4FE0, 9'd20);
      run_request("max_length", 32'h0000_7E00, 9'd256);
      next_cycle();

      if (assert_failures != 0) begin
         $display("TESTS FAILED");
         $fatal(1, "Assertion failures at end of run");
      end else begin
         $display("TESTS PASSED");
         $finish;
      end
   end

endmodule

`default_nettype wire

/* tb.f */
logic/axi_rd_pkg.sv
logic/xfer_pkg.sv
logic/axi_r_if.sv
logic/ar_burst_planner.sv
logic/r_skid_buffer.sv
logic/axis_read_dma.sv
verif/axi_mem_model.sv
verif/axis_read_dma_assert.sv
verif/tb_axis_read_dma.sv
